//--- source/fpAddPkg.sv
// Binary32 only; every stage struct carries its own valid bit and all words follow IEEE-754 layout
package fpAddPkg;

    // Field widths of the binary32 format
    localparam int EXP_BITS  = 8;
    localparam int FRAC_BITS = 23;

    // One binary32 word as it appears on the bus
    typedef struct packed {
        logic                 sign;
        logic [EXP_BITS-1:0]  exponent;
        logic [FRAC_BITS-1:0] fraction;
    } fpWord_t;

    // Alignment to adder
    // Slot A always holds the operand with the larger effective exponent,
    // guard, round and sticky belong to the shifted slot B
    typedef struct packed {
        logic                 valid;
        logic                 signA;
        logic                 signB;
        logic [EXP_BITS-1:0]  exponent;
        logic [FRAC_BITS:0]   mantissaA;
        logic [FRAC_BITS:0]   mantissaB;
        logic                 guard;
        logic                 round;
        logic                 sticky;
    } alignedPair_t;

    // Adder to round stage, exponent is one bit wider to hold a carry
    typedef struct packed {
        logic                 valid;
        logic                 sign;
        logic [EXP_BITS:0]    exponent;
        logic [FRAC_BITS:0]   mantissa;
        logic                 guard;
        logic                 round;
        logic                 sticky;
        logic                 isZero;
    } sumResult_t;

    // Pending NaN, infinity or signed zero result
    typedef struct packed {
        logic    active;
        fpWord_t value;
    } specialResult_t;

    localparam logic [EXP_BITS-1:0] EXP_MAX = '1;

    localparam fpWord_t QUIET_NAN = 32'h7FC00000;
    localparam fpWord_t POS_INF   = '{sign: 1'b0, exponent: EXP_MAX, fraction: '0};
    localparam fpWord_t NEG_INF   = '{sign: 1'b1, exponent: EXP_MAX, fraction: '0};

endpackage

//--- source/alignment.sv
// Stage 1 of 3; exponent 255 operands pass through unchecked since specialCases overrides them
`timescale 1ns/1ps

module alignment
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   inValid,
    input  fpAddPkg::fpWord_t      operandA,
    input  fpAddPkg::fpWord_t      operandB,
    output fpAddPkg::alignedPair_t aligned
);

    import fpAddPkg::*;

    logic         hiddenA;
    logic         hiddenB;
    logic [7:0]   effExpA;
    logic [7:0]   effExpB;
    logic [23:0]  sigA;
    logic [23:0]  sigB;
    logic         aLarger;
    logic [7:0]   expDiff;
    logic [4:0]   shiftAmount;
    logic [23:0]  smallSig;
    logic [49:0]  shifted;
    alignedPair_t alignedNext;

    // A zero exponent field means a subnormal or zero
    // It behaves as exponent 1 without the hidden bit
    assign hiddenA = |operandA.exponent;
    assign hiddenB = |operandB.exponent;
    assign effExpA = hiddenA ? operandA.exponent : 8'd1;
    assign effExpB = hiddenB ? operandB.exponent : 8'd1;
    assign sigA    = {hiddenA, operandA.fraction};
    assign sigB    = {hiddenB, operandB.fraction};

    always_comb
    begin
        aLarger           = (effExpA >= effExpB);
        alignedNext.valid = inValid;

        // Put the larger operand in slot A so the adder knows where GRS belongs
        if (aLarger)
        begin
            alignedNext.signA     = operandA.sign;
            alignedNext.signB     = operandB.sign;
            alignedNext.exponent  = effExpA;
            alignedNext.mantissaA = sigA;
            smallSig              = sigB;
            expDiff               = effExpA - effExpB;
        end
        else
        begin
            alignedNext.signA     = operandB.sign;
            alignedNext.signB     = operandA.sign;
            alignedNext.exponent  = effExpB;
            alignedNext.mantissaA = sigB;
            smallSig              = sigA;
            expDiff               = effExpB - effExpA;
        end

        // Beyond 26 places every bit of the small significand lands in sticky
        shiftAmount = (expDiff > 8'd26) ? 5'd26 : expDiff[4:0];

        // Bits 25 and 24 become guard and round, the rest collapse into sticky
        shifted               = {smallSig, 26'd0} >> shiftAmount;
        alignedNext.mantissaB = shifted[49:26];
        alignedNext.guard     = shifted[25];
        alignedNext.round     = shifted[24];
        alignedNext.sticky    = |shifted[23:0];
    end

    always_ff @(posedge clk)
    begin
        aligned <= alignedNext;
        if (rst)
            aligned.valid <= 1'b0;
    end

    // The chosen exponent must cover both operands of the previous cycle
    exponentCoversInputs: assert property (
        @(posedge clk) disable iff (rst)
        aligned.valid |-> (aligned.exponent >= $past(effExpA)) &&
                          (aligned.exponent >= $past(effExpB))
    );

endmodule

//--- source/specialCases.sv
// Runs beside the numeric path with two cycles of delay; NaN payloads are not kept, always 7FC00000
`timescale 1ns/1ps

module specialCases
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     inValid,
    input  fpAddPkg::fpWord_t        operandA,
    input  fpAddPkg::fpWord_t        operandB,
    output fpAddPkg::specialResult_t special
);

    import fpAddPkg::*;

    logic           nanA;
    logic           nanB;
    logic           infA;
    logic           infB;
    logic           zeroA;
    logic           zeroB;
    specialResult_t specialNext;
    specialResult_t stage1;

    // Operand classes
    assign nanA  = (operandA.exponent == EXP_MAX) && (|operandA.fraction);
    assign nanB  = (operandB.exponent == EXP_MAX) && (|operandB.fraction);
    assign infA  = (operandA.exponent == EXP_MAX) && !(|operandA.fraction);
    assign infB  = (operandB.exponent == EXP_MAX) && !(|operandB.fraction);
    assign zeroA = (operandA.exponent == 8'd0) && !(|operandA.fraction);
    assign zeroB = (operandB.exponent == 8'd0) && !(|operandB.fraction);

    always_comb
    begin
        specialNext.active = inValid;
        specialNext.value  = QUIET_NAN;
        if (nanA || nanB)
            specialNext.value = QUIET_NAN;
        else if (infA && infB && (operandA.sign != operandB.sign))
            specialNext.value = QUIET_NAN;
        else if (infA)
            specialNext.value = operandA.sign ? NEG_INF : POS_INF;
        else if (infB)
            specialNext.value = operandB.sign ? NEG_INF : POS_INF;
        else if (zeroA && zeroB)
            // -0 only when both zeros are negative
            specialNext.value = '{sign: operandA.sign & operandB.sign, exponent: 8'd0,
                                  fraction: 23'd0};
        else
            specialNext.active = 1'b0;
    end

    // Two-deep delay line to meet the sum of the same operands in roundPack
    always_ff @(posedge clk)
    begin
        stage1  <= specialNext;
        special <= stage1;
        if (rst)
        begin
            stage1.active  <= 1'b0;
            special.active <= 1'b0;
        end
    end

    activeNeedsStrobe: assert property (
        @(posedge clk) disable iff (rst)
        special.active |-> $past(inValid, 2)
    );

endmodule

//--- source/mantissaAdder.sv
// Stage 2 of 3; expects slot A to hold the larger exponent, result exponent never falls below 1
`timescale 1ns/1ps

module mantissaAdder
(
    input  logic                   clk,
    input  logic                   rst,
    input  fpAddPkg::alignedPair_t aligned,
    output fpAddPkg::sumResult_t   result
);

    import fpAddPkg::*;

    logic [26:0] magA;
    logic [26:0] magB;
    logic [27:0] rawSum;
    logic [26:0] magnitude;
    logic [8:0]  expWide;
    logic        sumSign;
    logic [4:0]  leadingZeros;
    logic [8:0]  maxShift;
    logic [4:0]  shiftLeft;
    logic [26:0] normalized;
    sumResult_t  resultNext;

    function automatic logic [4:0] countLeadingZeros(input logic [26:0] value);
        logic [4:0] count;
        logic       found;
        count = 5'd0;
        found = 1'b0;
        for (int i = 26; i >= 0; i--)
        begin
            if (value[i])
                found = 1'b1;
            else if (!found)
                count = count + 5'd1;
        end
        return count;
    endfunction

    always_comb
    begin
        // Significand with three extra bits, only B has guard, round, sticky
        magA    = {aligned.mantissaA, 3'b000};
        magB    = {aligned.mantissaB, aligned.guard, aligned.round, aligned.sticky};
        expWide = {1'b0, aligned.exponent};

        if (aligned.signA == aligned.signB)
        begin
            rawSum  = {1'b0, magA} + {1'b0, magB};
            sumSign = aligned.signA;
        end
        else if (magA >= magB)
        begin
            rawSum  = {1'b0, magA - magB};
            sumSign = aligned.signA;
        end
        else
        begin
            rawSum  = {1'b0, magB - magA};
            sumSign = aligned.signB;
        end

        // Carry out, shift right once and fold the lost bit into sticky
        if (rawSum[27])
        begin
            magnitude = {rawSum[27:2], rawSum[1] | rawSum[0]};
            expWide   = expWide + 9'd1;
        end
        else
            magnitude = rawSum[26:0];

        // Left shift stops at exponent 1, which leaves a subnormal
        leadingZeros = countLeadingZeros(magnitude);
        maxShift     = expWide - 9'd1;
        if ({4'd0, leadingZeros} > maxShift)
            shiftLeft = maxShift[4:0];
        else
            shiftLeft = leadingZeros;
        normalized = magnitude << shiftLeft;

        resultNext.valid    = aligned.valid;
        resultNext.isZero   = (magnitude == 27'd0);
        resultNext.sign     = resultNext.isZero ? 1'b0 : sumSign;
        resultNext.exponent = expWide - {4'd0, shiftLeft};
        resultNext.mantissa = normalized[26:3];
        resultNext.guard    = normalized[2];
        resultNext.round    = normalized[1];
        resultNext.sticky   = normalized[0];
    end

    always_ff @(posedge clk)
    begin
        result <= resultNext;
        if (rst)
            result.valid <= 1'b0;
    end

    normalizedAboveOne: assert property (
        @(posedge clk) disable iff (rst)
        (result.valid && !result.isZero && (result.exponent > 9'd1)) |-> result.mantissa[23]
    );

endmodule

//--- source/roundPack.sv
// Stage 3 of 3; round to nearest even only, no exception flags, special result wins when active
`timescale 1ns/1ps

module roundPack
(
    input  logic                     clk,
    input  logic                     rst,
    input  fpAddPkg::sumResult_t     result,
    input  fpAddPkg::specialResult_t special,
    output logic                     outValid,
    output fpAddPkg::fpWord_t        sum
);

    import fpAddPkg::*;

    logic        roundUp;
    logic [24:0] rounded;
    logic [23:0] finalMant;
    logic [8:0]  roundedExp;
    fpWord_t     numeric;

    always_comb
    begin
        // Ties go to the even mantissa
        roundUp = result.guard & (result.round | result.sticky | result.mantissa[0]);
        rounded = {1'b0, result.mantissa} + {24'd0, roundUp};

        if (rounded[24])
        begin
            finalMant  = rounded[24:1];
            roundedExp = result.exponent + 9'd1;
        end
        else
        begin
            finalMant  = rounded[23:0];
            roundedExp = result.exponent;
        end

        if (result.isZero)
            numeric = '{sign: result.sign, exponent: 8'd0, fraction: 23'd0};
        else if (roundedExp >= 9'd255)
            numeric = result.sign ? NEG_INF : POS_INF;
        else
            // Clear hidden bit packs as a subnormal
            numeric = '{sign: result.sign,
                        exponent: finalMant[23] ? roundedExp[7:0] : 8'd0,
                        fraction: finalMant[22:0]};
    end

    always_ff @(posedge clk)
    begin
        sum <= special.active ? special.value : numeric;
        if (rst)
            outValid <= 1'b0;
        else
            outValid <= result.valid;
    end

    // Both side paths must deliver the same operands in the same cycle
    specialMatchesNumeric: assert property (
        @(posedge clk) disable iff (rst)
        special.active |-> result.valid
    );

endmodule

//--- source/fpAdder.sv
// Binary32 adder with fixed 3-cycle latency; no back-pressure, every outValid must be taken
`timescale 1ns/1ps

module fpAdder
(
    input  logic              clk,
    input  logic              rst,
    input  logic              inValid,
    input  fpAddPkg::fpWord_t operandA,
    input  fpAddPkg::fpWord_t operandB,
    output logic              outValid,
    output fpAddPkg::fpWord_t sum
);

    import fpAddPkg::*;

    alignedPair_t   aligned;
    sumResult_t     result;
    specialResult_t special;

    // Numeric path
    alignment u_alignment (
        .clk      (clk),
        .rst      (rst),
        .inValid  (inValid),
        .operandA (operandA),
        .operandB (operandB),
        .aligned  (aligned)
    );

    mantissaAdder u_mantissaAdder (
        .clk     (clk),
        .rst     (rst),
        .aligned (aligned),
        .result  (result)
    );

    // Runs beside the numeric path
    specialCases u_specialCases (
        .clk      (clk),
        .rst      (rst),
        .inValid  (inValid),
        .operandA (operandA),
        .operandB (operandB),
        .special  (special)
    );

    roundPack u_roundPack (
        .clk      (clk),
        .rst      (rst),
        .result   (result),
        .special  (special),
        .outValid (outValid),
        .sum      (sum)
    );

endmodule

//--- test/fpAdderTb.sv
// Run from the project root so test/fpAdderTrace.txt is found; assumes the fixed 3-cycle latency
`timescale 1ns/1ps

module fpAdderTb;

    import fpAddPkg::*;

    localparam int LATENCY      = 3;
    localparam int RESET_CYCLES = 16;

    logic        clk;
    logic        rst;
    logic        inValid;
    fpWord_t     operandA;
    fpWord_t     operandB;
    logic        outValid;
    fpWord_t     sum;

    // Trace contents
    fpWord_t     traceA[$];
    fpWord_t     traceB[$];
    fpWord_t     traceSum[$];
    string       traceLabel[$];

    // Scoreboard, one entry per issued test
    fpWord_t     expectQ[$];
    string       labelQ[$];
    int          dueQ[$];

    logic [31:0] lfsrState;
    int          cycleCount;
    int          timeoutLimit;
    int          passCount;
    int          failCount;
    int          errorCount;

    fpAdder u_dut (
        .clk      (clk),
        .rst      (rst),
        .inValid  (inValid),
        .operandA (operandA),
        .operandB (operandB),
        .outValid (outValid),
        .sum      (sum)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Fibonacci LFSR with taps 32, 22, 2, 1
    function automatic logic [31:0] nextLfsr(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    // Two bits per test, so gaps of 0 to 3 idle cycles
    task automatic drawGap(output int gap);
        logic [1:0] bits;
        for (int k = 0; k < 2; k++)
        begin
            lfsrState = nextLfsr(lfsrState);
            bits[k]   = lfsrState[0];
        end
        gap = bits;
    endtask

    task automatic loadTrace();
        int          fd;
        int          fields;
        string       line;
        string       label;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] s;
        fd = $fopen("test/fpAdderTrace.txt", "r");
        if (fd == 0)
        begin
            $display("Cannot open test/fpAdderTrace.txt");
            errorCount++;
            return;
        end
        while (!$feof(fd))
        begin
            line = "";
            if ($fgets(line, fd) == 0)
                break;
            // Comment and blank lines hold no hex word and scan as zero fields
            fields = $sscanf(line, "%h %h %h %s", a, b, s, label);
            if (fields == 4)
            begin
                traceA.push_back(a);
                traceB.push_back(b);
                traceSum.push_back(s);
                traceLabel.push_back(label);
            end
            else if (fields > 0)
            begin
                $display("Malformed trace line: %s", line);
                errorCount++;
            end
        end
        $fclose(fd);
    endtask

    task automatic checkSum(input fpWord_t got, input fpWord_t expected, input string label);
        if (got === expected)
        begin
            $display("ok %s sum=%h", label, got);
            passCount++;
        end
        else
        begin
            $display("MISMATCH sum %s: got %h expected %h", label, got, expected);
            failCount++;
        end
    endtask

    task automatic checkStrobe(input logic valid, input fpWord_t got);
        if (valid === 1'b1)
        begin
            if (expectQ.size() == 0)
            begin
                $display("Unexpected outValid at cycle %0d with no test pending", cycleCount);
                errorCount++;
            end
            else
            begin
                if (dueQ[0] != cycleCount)
                begin
                    $display("Result for %s came at cycle %0d instead of cycle %0d",
                             labelQ[0], cycleCount, dueQ[0]);
                    errorCount++;
                end
                checkSum(got, expectQ[0], labelQ[0]);
                void'(expectQ.pop_front());
                void'(labelQ.pop_front());
                void'(dueQ.pop_front());
            end
        end
        else if (valid !== 1'b0)
        begin
            $display("outValid is unknown at cycle %0d", cycleCount);
            errorCount++;
        end
        else if (dueQ.size() != 0 && dueQ[0] <= cycleCount)
        begin
            $display("No result strobe for %s at cycle %0d", labelQ[0], dueQ[0]);
            failCount++;
            void'(expectQ.pop_front());
            void'(labelQ.pop_front());
            void'(dueQ.pop_front());
        end
    endtask

    always @(posedge clk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutLimit)
        begin
            $display("Timeout at cycle %0d with %0d results outstanding",
                     cycleCount, expectQ.size());
            $display("Simulation FAILED");
            $finish;
        end
    end

    // Outputs are registered, so they are stable at the falling edge
    always @(negedge clk)
        checkStrobe(outValid, sum);

    initial
    begin
        int gap;
        rst          = 1'b1;
        inValid      = 1'b0;
        operandA     = '0;
        operandB     = '0;
        lfsrState    = 32'h1a7f;
        cycleCount   = 0;
        passCount    = 0;
        failCount    = 0;
        errorCount   = 0;

        loadTrace();
        if (traceA.size() == 0)
        begin
            $display("No tests were loaded from the trace");
            errorCount++;
        end
        timeoutLimit = RESET_CYCLES + 4 * traceA.size() + LATENCY + 20;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < traceA.size(); i++)
        begin
            drawGap(gap);
            repeat (gap)
            begin
                @(negedge clk);
                inValid = 1'b0;
            end
            @(negedge clk);
            inValid  = 1'b1;
            operandA = traceA[i];
            operandB = traceB[i];
            expectQ.push_back(traceSum[i]);
            labelQ.push_back(traceLabel[i]);
            dueQ.push_back(cycleCount + LATENCY);
        end
        @(negedge clk);
        inValid = 1'b0;

        while (expectQ.size() != 0)
            @(negedge clk);
        // A few quiet cycles to catch stray strobes
        repeat (5) @(negedge clk);

        $display("Tests passed %0d, failed %0d, other errors %0d",
                 passCount, failCount, errorCount);
        if (failCount == 0 && errorCount == 0 && passCount == traceA.size() && passCount > 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

//--- project.f
source/fpAddPkg.sv
source/alignment.sv
source/specialCases.sv
source/mantissaAdder.sv
source/roundPack.sv
source/fpAdder.sv
test/fpAdderTb.sv

//--- Bender.yml
package:
  name: fpadder

sources:
  - files:
      - source/fpAddPkg.sv
      - source/alignment.sv
      - source/specialCases.sv
      - source/mantissaAdder.sv
      - source/roundPack.sv
      - source/fpAdder.sv
  - target: test
    files:
      - test/fpAdderTb.sv

//--- test/fpAdderTrace.txt
# operandA operandB expectedSum label
# binary32 words in hex, one test per line
3F800000 3F800000 40000000 one_plus_one
3F800000 40000000 40400000 one_plus_two
3FC00000 3FC00000 40400000 equal_exp_carry
3F800000 40400000 40800000 one_plus_three
3DCCCCCD 3E4CCCCD 3E99999A tenth_plus_fifth
3F800000 33800000 3F800000 tie_to_even_down
3F800001 33800000 3F800002 tie_to_even_up
3F800000 33C00000 3F800001 above_half_up
3F800001 3F800000 40000000 carry_tie_even
3F800003 3F800000 40000002 carry_tie_up
40400000 BF800000 40000000 three_minus_one
40400000 C0000000 3F800000 three_minus_two
3F800000 BF800000 00000000 exact_cancel
BF800000 3F800000 00000000 exact_cancel_neg_first
3F800000 BF7FFFFF 33800000 deep_cancel
3F800001 BF800000 34000000 one_ulp_left
3F800000 B3000001 3F7FFFFF cancel_sticky_down
3F800000 B3000000 3F800000 cancel_tie_even
00000001 00000001 00000002 tiny_plus_tiny
00400000 00400000 00800000 subnormal_to_normal
007FFFFF 00000001 00800000 max_sub_plus_tiny
00800000 80000001 007FFFFF normal_minus_tiny
00800001 80800000 00000001 normal_to_subnormal
80000003 00000001 80000002 neg_subnormal
3F800000 00000001 3F800000 huge_shift_sticky
4F800000 BF800000 4F800000 huge_shift_round_up
7FC00000 3F800000 7FC00000 qnan_operand
7F800001 00000000 7FC00000 snan_operand
3F800000 FFC00001 7FC00000 neg_nan_operand
7F800000 FF800000 7FC00000 inf_minus_inf
7F800000 3F800000 7F800000 inf_plus_one
7F800000 7F800000 7F800000 inf_plus_inf
80000000 80000000 80000000 neg_zero_sum
00000000 80000000 00000000 mixed_zero_sum
7F7FFFFF 7F7FFFFF 7F800000 overflow_pos
FF7FFFFF FF7FFFFF FF800000 overflow_neg
7F7FFFFF 73000000 7F800000 round_overflow
